//--- common/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	// kernel geometry
	localparam int KERNEL = 3;
	localparam int TAPS = KERNEL * KERNEL;

	typedef logic signed [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;

	// channel result truncated to 16 bits
	typedef logic signed [15:0] acc_t;

	// row or col index and coefficient address
	typedef logic [7:0] coord_t;

	// [row][col] with row 0 the oldest and col 0 the leftmost
	typedef pixel_t [KERNEL-1:0][KERNEL-1:0] window_t;

endpackage

`default_nettype wire

//--- hw/window/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
	parameter int DEPTH = 5
) (
	input logic clk,
	input logic rst,
	input cnn_pkg::pixel_t din,
	output cnn_pkg::pixel_t dout
);
	import cnn_pkg::*;

	pixel_t taps [DEPTH];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				taps[i] <= '0;
			end
		end
		else
		begin
			taps[0] <= din;
			for (int i = 1; i < DEPTH; i++)
			begin
				taps[i] <= taps[i-1];
			end
		end
	end

	assign dout = taps[DEPTH-1];

endmodule

`default_nettype wire

//--- hw/window/conv_window.sv
`timescale 1ns/1ps
`default_nettype none

module conv_window #(
	parameter int IMG_W = 8
) (
	input logic clk,
	input logic rst,
	input cnn_pkg::pixel_t pixel_data,
	output cnn_pkg::window_t window
);
	import cnn_pkg::*;

	// rest of the row behind each of the two newer window rows
	pixel_t row_tail [2];

	line_buffer #(.DEPTH(IMG_W - KERNEL)) u_lb_new (
		.clk(clk),
		.rst(rst),
		.din(window[2][0]),
		.dout(row_tail[1])
	);

	line_buffer #(.DEPTH(IMG_W - KERNEL)) u_lb_mid (
		.clk(clk),
		.rst(rst),
		.din(window[1][0]),
		.dout(row_tail[0])
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			window <= '0;
		end
		else
		begin
			// col 2 takes the newest pixel of its row
			window[2][2] <= pixel_data;
			window[1][2] <= row_tail[1];
			window[0][2] <= row_tail[0];
			for (int r = 0; r < KERNEL; r++)
			begin
				window[r][1] <= window[r][2];
				window[r][0] <= window[r][1];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/coef_loader.sv
`timescale 1ns/1ps
`default_nettype none

module coef_loader #(
	parameter type coef_t = logic [7:0],
	parameter int COUNT = 1
) (
	input logic clk,
	input logic rst,
	input logic store_done,
	input coef_t rdata,
	output logic read,
	output cnn_pkg::coord_t addr,
	output coef_t coefs [COUNT]
);
	import cnn_pkg::*;

	typedef enum logic {
		IDLE,
		LOAD
	} state_t;

	state_t state;
	logic loaded;
	logic capture;

	assign read = (state == LOAD);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= IDLE;
			addr <= '0;
			loaded <= 1'b0;
			capture <= 1'b0;
		end
		else
		begin
			// data comes back one cycle after the strobe
			capture <= read;
			case (state)
				IDLE:
				begin
					if (store_done && !loaded)
					begin
						state <= LOAD;
						addr <= '0;
					end
				end
				LOAD:
				begin
					if (addr == coord_t'(COUNT - 1))
					begin
						state <= IDLE;
						loaded <= 1'b1;
					end
					else
					begin
						addr <= addr + 1'b1;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// first word ends up in entry 0 after COUNT shifts
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			coefs[COUNT-1] <= rdata;
			for (int i = 0; i < COUNT - 1; i++)
			begin
				coefs[i] <= coefs[i+1];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/mac_channel.sv
`timescale 1ns/1ps
`default_nettype none

module mac_channel (
	input cnn_pkg::window_t window,
	input cnn_pkg::weight_t weights [cnn_pkg::TAPS],
	input cnn_pkg::bias_t bias,
	output cnn_pkg::acc_t result
);
	import cnn_pkg::*;

	// nine 16-bit products need 20 bits before truncation
	localparam int SUM_W = 20;

	logic signed [SUM_W-1:0] prod [TAPS];
	logic signed [SUM_W-1:0] pair [4];
	logic signed [SUM_W-1:0] quad [2];
	logic signed [SUM_W-1:0] total;

	always_comb
	begin
		for (int t = 0; t < TAPS; t++)
		begin
			prod[t] = $signed(window[t / KERNEL][t % KERNEL]) * $signed(weights[t]);
		end
		for (int i = 0; i < 4; i++)
		begin
			pair[i] = prod[2*i] + prod[2*i+1];
		end
		quad[0] = pair[0] + pair[1];
		quad[1] = pair[2] + pair[3];
		// last tap joins the bias at the root
		total = (quad[0] + quad[1]) + (prod[TAPS-1] + bias);
	end

	assign result = acc_t'(total[15:0]);

endmodule

`default_nettype wire

//--- hw/save_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module save_ctrl #(
	parameter int IMG_W = 8,
	parameter int IMG_H = 6
) (
	input logic clk,
	input logic rst,
	input logic pixel_store_done,
	output logic read_pixel,
	output cnn_pkg::coord_t read_row_addr,
	output cnn_pkg::coord_t read_col_addr,
	output logic save_enable,
	output cnn_pkg::coord_t output_row,
	output cnn_pkg::coord_t output_col,
	output logic calculation_done
);
	import cnn_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		STREAM,
		DRAIN
	} state_t;

	state_t state;
	coord_t row_cnt;
	coord_t col_cnt;
	logic last_read;

	// read coordinates in flight
	logic s1_valid;
	logic s2_valid;
	coord_t s1_row;
	coord_t s1_col;
	coord_t s2_row;
	coord_t s2_col;
	logic s2_last;

	assign read_pixel = (state == STREAM);
	assign read_row_addr = row_cnt;
	assign read_col_addr = col_cnt;
	assign last_read = (row_cnt == coord_t'(IMG_H - 1)) && (col_cnt == coord_t'(IMG_W - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= IDLE;
			row_cnt <= '0;
			col_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					row_cnt <= '0;
					col_cnt <= '0;
					if (pixel_store_done)
					begin
						state <= STREAM;
					end
				end
				STREAM:
				begin
					if (last_read)
					begin
						state <= DRAIN;
						row_cnt <= '0;
						col_cnt <= '0;
					end
					else if (col_cnt == coord_t'(IMG_W - 1))
					begin
						col_cnt <= '0;
						row_cnt <= row_cnt + 1'b1;
					end
					else
					begin
						col_cnt <= col_cnt + 1'b1;
					end
				end
				DRAIN:
				begin
					// wait for the last pixel to reach the window
					if (s2_last)
					begin
						state <= IDLE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			calculation_done <= 1'b0;
		end
		else
		begin
			s1_valid <= read_pixel;
			s2_valid <= s1_valid;
			calculation_done <= s2_last;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_row <= row_cnt;
		s1_col <= col_cnt;
		s2_row <= s1_row;
		s2_col <= s1_col;
	end

	assign s2_last = s2_valid && (s2_row == coord_t'(IMG_H - 1))
		&& (s2_col == coord_t'(IMG_W - 1));

	// window is complete once the newest pixel is at row 2, col 2 or beyond
	assign save_enable = s2_valid && (s2_row >= coord_t'(KERNEL - 1))
		&& (s2_col >= coord_t'(KERNEL - 1));
	assign output_row = s2_row - coord_t'(KERNEL - 1);
	assign output_col = s2_col - coord_t'(KERNEL - 1);

endmodule

`default_nettype wire

//--- hw/cnn_layer1.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_layer1 #(
	parameter int IMG_W = 8,
	parameter int IMG_H = 6,
	parameter int OUT_CH = 4
) (
	input logic clk,
	input logic rst,
	input logic weight_store_done,
	input logic bias_store_done,
	input logic pixel_store_done,
	input cnn_pkg::pixel_t pixel_data,
	input cnn_pkg::weight_t weight_data,
	input cnn_pkg::bias_t bias_data,
	output logic read_pixel,
	output cnn_pkg::coord_t read_row_addr,
	output cnn_pkg::coord_t read_col_addr,
	output logic read_weight,
	output cnn_pkg::coord_t read_weight_addr,
	output logic read_bias,
	output cnn_pkg::coord_t read_bias_addr,
	output logic save_enable,
	output cnn_pkg::coord_t output_row,
	output cnn_pkg::coord_t output_col,
	output logic [OUT_CH*16-1:0] output_data,
	output logic calculation_done
);
	import cnn_pkg::*;

	weight_t all_weights [OUT_CH*TAPS];
	bias_t all_bias [OUT_CH];
	window_t window;

	coef_loader #(.coef_t(weight_t), .COUNT(OUT_CH * TAPS)) weight_loader (
		.clk(clk),
		.rst(rst),
		.store_done(weight_store_done),
		.rdata(weight_data),
		.read(read_weight),
		.addr(read_weight_addr),
		.coefs(all_weights)
	);

	coef_loader #(.coef_t(bias_t), .COUNT(OUT_CH)) bias_loader (
		.clk(clk),
		.rst(rst),
		.store_done(bias_store_done),
		.rdata(bias_data),
		.read(read_bias),
		.addr(read_bias_addr),
		.coefs(all_bias)
	);

	conv_window #(.IMG_W(IMG_W)) u_window (
		.clk(clk),
		.rst(rst),
		.pixel_data(pixel_data),
		.window(window)
	);

	save_ctrl #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_save_ctrl (
		.clk(clk),
		.rst(rst),
		.pixel_store_done(pixel_store_done),
		.read_pixel(read_pixel),
		.read_row_addr(read_row_addr),
		.read_col_addr(read_col_addr),
		.save_enable(save_enable),
		.output_row(output_row),
		.output_col(output_col),
		.calculation_done(calculation_done)
	);

	for (genvar k = 0; k < OUT_CH; k++)
	begin : g_ch
		// channel k owns weight addresses 9k .. 9k+8
		weight_t ch_weights [TAPS];

		for (genvar t = 0; t < TAPS; t++)
		begin : g_tap
			assign ch_weights[t] = all_weights[k*TAPS + t];
		end

		mac_channel u_mac (
			.window(window),
			.weights(ch_weights),
			.bias(all_bias[k]),
			.result(output_data[16*k +: 16])
		);
	end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- dv/tb_cnn_layer1.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_layer1;
	import cnn_pkg::*;

	localparam int IMG_W = 8;
	localparam int IMG_H = 6;
	localparam int OUT_CH = 4;
	localparam int CLK_PERIOD = 4;
	localparam int N_WEIGHTS = OUT_CH * TAPS;
	localparam int N_PIXELS = IMG_W * IMG_H;
	localparam int OUT_W = IMG_W - KERNEL + 1;
	localparam int N_SAVES = OUT_W * (IMG_H - KERNEL + 1);
	// reset, idle gaps, both loads and two frames with their drain
	localparam int TEST_CYCLES = 8 + 4 + N_WEIGHTS + 20 + 2 * (N_PIXELS + 6);

	logic clk;
	logic rst = 1'b1;
	logic weight_store_done = 1'b0;
	logic bias_store_done = 1'b0;
	logic pixel_store_done = 1'b0;
	pixel_t pixel_data = '0;
	weight_t weight_data = '0;
	bias_t bias_data = '0;
	logic read_pixel;
	logic read_weight;
	logic read_bias;
	logic save_enable;
	logic calculation_done;
	coord_t read_row_addr;
	coord_t read_col_addr;
	coord_t read_weight_addr;
	coord_t read_bias_addr;
	coord_t output_row;
	coord_t output_col;
	logic [OUT_CH*16-1:0] output_data;

	// reference contents of the external memories
	weight_t weight_mem [N_WEIGHTS];
	bias_t bias_mem [OUT_CH];
	pixel_t image_mem [2][N_PIXELS];

	int frame = 0;
	logic started = 1'b0;
	int weight_reads = 0;
	int bias_reads = 0;
	int pixel_reads = 0;
	int save_count = 0;
	int frames_done = 0;

	tb_clock #(.PERIOD(CLK_PERIOD)) clock_gen (
		.clk(clk)
	);

	cnn_layer1 #(.IMG_W(IMG_W), .IMG_H(IMG_H), .OUT_CH(OUT_CH)) dut (
		.clk(clk),
		.rst(rst),
		.weight_store_done(weight_store_done),
		.bias_store_done(bias_store_done),
		.pixel_store_done(pixel_store_done),
		.pixel_data(pixel_data),
		.weight_data(weight_data),
		.bias_data(bias_data),
		.read_pixel(read_pixel),
		.read_row_addr(read_row_addr),
		.read_col_addr(read_col_addr),
		.read_weight(read_weight),
		.read_weight_addr(read_weight_addr),
		.read_bias(read_bias),
		.read_bias_addr(read_bias_addr),
		.save_enable(save_enable),
		.output_row(output_row),
		.output_col(output_col),
		.output_data(output_data),
		.calculation_done(calculation_done)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// {row, col} of entry index in a raster of the given width
	function automatic logic [15:0] raster_pos(input int index, input int width);
		return {8'(index / width), 8'(index % width)};
	endfunction

	function automatic logic [OUT_CH*16-1:0] expected_output(input int img, input int orow,
		input int ocol);
		logic [OUT_CH*16-1:0] result;
		int sum;
		for (int k = 0; k < OUT_CH; k++)
		begin
			sum = int'(bias_mem[k]);
			for (int i = 0; i < KERNEL; i++)
			begin
				for (int j = 0; j < KERNEL; j++)
				begin
					sum += int'(weight_mem[TAPS * k + KERNEL * i + j])
						* int'(image_mem[img][(orow + i) * IMG_W + ocol + j]);
				end
			end
			result[16*k +: 16] = sum[15:0];
		end
		return result;
	endfunction

	task automatic end_with_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string test, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
		end_with_failure();
	endtask

	task automatic report_error(input string what);
		$display("ERROR: %s", what);
		end_with_failure();
	endtask

	task automatic fill_memories();
		logic [31:0] rng;
		rng = 32'd48712;
		for (int i = 0; i < N_WEIGHTS; i++)
		begin
			rng = xorshift32(rng);
			weight_mem[i] = weight_t'(rng[7:0]);
		end
		for (int i = 0; i < OUT_CH; i++)
		begin
			rng = xorshift32(rng);
			bias_mem[i] = bias_t'(rng[15:0]);
		end
		for (int f = 0; f < 2; f++)
		begin
			for (int p = 0; p < N_PIXELS; p++)
			begin
				rng = xorshift32(rng);
				image_mem[f][p] = pixel_t'(rng[7:0]);
			end
		end
	endtask

	task automatic load_coefficients();
		@(posedge clk);
		started <= 1'b1;
		weight_store_done <= 1'b1;
		bias_store_done <= 1'b1;
		@(posedge clk);
		weight_store_done <= 1'b0;
		bias_store_done <= 1'b0;
	endtask

	task automatic wait_for_loads();
		do
			@(negedge clk);
		while (weight_reads < N_WEIGHTS || bias_reads < OUT_CH || read_weight || read_bias);
	endtask

	task automatic run_frame(input int img);
		@(posedge clk);
		frame <= img;
		pixel_store_done <= 1'b1;
		@(posedge clk);
		pixel_store_done <= 1'b0;
		do
			@(negedge clk);
		while (!calculation_done);
	endtask

	// memory models answer one cycle after the strobe
	always @(posedge clk)
	begin
		if (read_pixel)
			pixel_data <= image_mem[frame][int'(read_row_addr) * IMG_W + int'(read_col_addr)];
		if (read_weight)
			weight_data <= weight_mem[read_weight_addr];
		if (read_bias)
			bias_data <= bias_mem[read_bias_addr];
	end

	always @(posedge clk)
	begin
		if (read_weight)
			weight_reads <= weight_reads + 1;
		if (read_bias)
			bias_reads <= bias_reads + 1;
		if (pixel_store_done)
		begin
			pixel_reads <= 0;
			save_count <= 0;
		end
		else
		begin
			if (read_pixel)
				pixel_reads <= pixel_reads + 1;
			if (save_enable)
				save_count <= save_count + 1;
		end
		if (calculation_done)
			frames_done <= frames_done + 1;
	end

	idle_after_reset: assert property (@(posedge clk) disable iff (rst)
		!started |-> !(read_pixel || read_weight || read_bias || save_enable || calculation_done))
		else report_error("a strobe or status output went high before any store-done pulse");

	weight_addr_order: assert property (@(posedge clk) disable iff (rst)
		read_weight |-> weight_reads < N_WEIGHTS && read_weight_addr == coord_t'(weight_reads))
		else report_mismatch("weight_addr", $sampled(weight_reads), $sampled(read_weight_addr));

	weight_strobe_count: assert property (@(posedge clk) disable iff (rst)
		$fell(read_weight) |-> weight_reads == N_WEIGHTS)
		else report_mismatch("weight_strobe_count", N_WEIGHTS, $sampled(weight_reads));

	bias_addr_order: assert property (@(posedge clk) disable iff (rst)
		read_bias |-> bias_reads < OUT_CH && read_bias_addr == coord_t'(bias_reads))
		else report_mismatch("bias_addr", $sampled(bias_reads), $sampled(read_bias_addr));

	bias_strobe_count: assert property (@(posedge clk) disable iff (rst)
		$fell(read_bias) |-> bias_reads == OUT_CH)
		else report_mismatch("bias_strobe_count", OUT_CH, $sampled(bias_reads));

	pixel_addr_order: assert property (@(posedge clk) disable iff (rst)
		read_pixel |-> pixel_reads < N_PIXELS
			&& {read_row_addr, read_col_addr} == raster_pos(pixel_reads, IMG_W))
		else report_mismatch("pixel_addr", raster_pos($sampled(pixel_reads), IMG_W),
			{$sampled(read_row_addr), $sampled(read_col_addr)});

	pixel_strobe_count: assert property (@(posedge clk) disable iff (rst)
		$fell(read_pixel) |-> pixel_reads == N_PIXELS)
		else report_mismatch("pixel_strobe_count", N_PIXELS, $sampled(pixel_reads));

	save_position: assert property (@(posedge clk) disable iff (rst)
		save_enable |-> save_count < N_SAVES
			&& {output_row, output_col} == raster_pos(save_count, OUT_W))
		else report_mismatch("save_position", raster_pos($sampled(save_count), OUT_W),
			{$sampled(output_row), $sampled(output_col)});

	output_value: assert property (@(posedge clk) disable iff (rst)
		save_enable |-> output_data == expected_output(frame, output_row, output_col))
		else report_mismatch("output_data",
			expected_output(frame, $sampled(output_row), $sampled(output_col)),
			$sampled(output_data));

	saves_per_frame: assert property (@(posedge clk) disable iff (rst)
		calculation_done |-> save_count == N_SAVES)
		else report_mismatch("save_count", N_SAVES, $sampled(save_count));

	done_pulse: assert property (@(posedge clk) disable iff (rst)
		calculation_done |-> $past(save_enable) && !$past(calculation_done))
		else report_error("calculation_done is not a one-cycle pulse right after the last save");

	initial
	begin
		#(20 * TEST_CYCLES * CLK_PERIOD);
		$display("ERROR: watchdog timeout after %0d cycles", 20 * TEST_CYCLES);
		end_with_failure();
	end

	initial
	begin
		fill_memories();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk);
		load_coefficients();
		wait_for_loads();
		// loaders must stay quiet on a repeated request
		load_coefficients();
		repeat (12) @(negedge clk);
		run_frame(0);
		run_frame(1);
		repeat (4) @(negedge clk);
		if (frames_done == 2 && weight_reads == N_WEIGHTS && bias_reads == OUT_CH)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
		begin
			report_error("run ended with missing frames or coefficient reads");
		end
	end

endmodule

`default_nettype wire

//--- cnn_layer1.f
common/cnn_pkg.sv
hw/window/line_buffer.sv
hw/window/conv_window.sv
hw/coef_loader.sv
hw/mac_channel.sv
hw/save_ctrl.sv
hw/cnn_layer1.sv
dv/tb_clock.sv
dv/tb_cnn_layer1.sv

//--- run.sh
#!/bin/sh
# build and run the cnn_layer1 testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_cnn_layer1 -f cnn_layer1.f
then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_cnn_layer1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx 'RESULT: PASS'; then
	exit 0
fi
exit 1
